// ==== lm80c_mem.f ====
+incdir+design
design/lm80c_mem_pkg.sv
design/mem_req_if.sv
design/clock_enables.sv
design/rom_loader.sv
design/ram_eraser.sv
design/mem_arbiter.sv
design/system_memory.sv
design/lm80c_mem.sv
verification/lm80c_mem_assert.sv
verification/lm80c_mem_tb.sv

// ==== verification/lm80c_mem_tb.sv ====
/*
  LM80C memory subsystem testbench
  Random downloads, CPU traffic and erase runs checked
  against a byte-level model of memory and boot state
*/
`default_nettype none

`include "lm80c_mem_settings.svh"

module lm80c_mem_tb;

	import lm80c_mem_pkg::*;

	localparam int DRIVE_DELAY = 2;
	localparam int ERASE_WORDS = 64;
	localparam int WAIT_LIMIT  = 2000;
	localparam int MEM_BYTES   = 1 << `LM80C_MEM_ADDR_W;

	logic      clk_sys;
	logic      rst;
	logic      ioctl_download;
	dl_index_t ioctl_index;
	dl_addr_t  ioctl_addr;
	mem_data_t ioctl_dout;
	logic      ioctl_wr;
	logic      user_reset;
	logic      menu_reset;
	cpu_addr_t cpu_addr;
	mem_data_t cpu_dout;
	logic      cpu_rd;
	logic      cpu_wr;
	logic      rom_enable;
	mem_data_t mem_q;
	logic      vdp_ena;
	logic      z80_ena;
	logic      psg_ena;
	logic      cpu_reset;
	logic      cpu_wait;
	logic      erasing;

	// ========================================
	// Model state
	// ========================================

	// Unwritten bytes stay X, as in the DUT array
	mem_data_t   model_mem [MEM_BYTES];
	logic        model_rom_loaded;
	// Download targets, offsets into the ROM bank
	logic [14:0] target_addrs [$];
	// CPU addresses written so far
	cpu_addr_t   cpu_written [$];

	integer seed;
	int     error_count;
	int     check_count;

	lm80c_mem #(
		.ERASE_WORDS (ERASE_WORDS)
	) DUT (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr),
		.user_reset     (user_reset),
		.menu_reset     (menu_reset),
		.cpu_addr       (cpu_addr),
		.cpu_dout       (cpu_dout),
		.cpu_rd         (cpu_rd),
		.cpu_wr         (cpu_wr),
		.rom_enable     (rom_enable),
		.mem_q          (mem_q),
		.vdp_ena        (vdp_ena),
		.z80_ena        (z80_ena),
		.psg_ena        (psg_ena),
		.cpu_reset      (cpu_reset),
		.cpu_wait       (cpu_wait),
		.erasing        (erasing)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ========================================
	// Helpers
	// ========================================

	// ROM shows in the lower 32K only while rom_enable is set
	function automatic mem_addr_t map_cpu_addr(input cpu_addr_t addr, input logic rom_en);
		if (rom_en && (addr < 16'h8000))
			return `LM80C_ROM_BASE + mem_addr_t'(addr);
		else
			return `LM80C_RAM_BASE + mem_addr_t'(addr);
	endfunction

	// Inputs change just after the rising edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#DRIVE_DELAY;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("FAILED at %0t: %s expected %0h got %0h", $time, name, expected, actual);
		end
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		repeat (2) begin
			next_cycle();
			check_value("vdp_ena", 0, vdp_ena);
			check_value("z80_ena", 0, z80_ena);
			check_value("psg_ena", 0, psg_ena);
		end
		rst = 1'b0;
		model_rom_loaded = 1'b0;
		// No ROM yet, so the CPU stays parked
		check_value("cpu_reset", 1, cpu_reset);
		check_value("cpu_wait", 1, cpu_wait);
	endtask

	task automatic cpu_write(input cpu_addr_t addr, input logic rom_en, input mem_data_t data);
		cpu_addr   = addr;
		rom_enable = rom_en;
		cpu_dout   = data;
		cpu_wr     = 1'b1;
		cpu_rd     = 1'b0;
		next_cycle();
		cpu_wr = 1'b0;
		model_mem[map_cpu_addr(addr, rom_en)] = data;
	endtask

	// Registered read, data shows one cycle later
	task automatic cpu_read(input cpu_addr_t addr, input logic rom_en);
		mem_data_t expected;
		expected   = model_mem[map_cpu_addr(addr, rom_en)];
		cpu_addr   = addr;
		rom_enable = rom_en;
		cpu_rd     = 1'b1;
		cpu_wr     = 1'b0;
		next_cycle();
		cpu_rd = 1'b0;
		check_value("mem_q", expected, mem_q);
	endtask

	// One byte per target address, strobe then idle cycle
	task automatic run_download(input dl_index_t idx);
		logic [31:0] rnd;
		logic        accepted;
		accepted = (idx == `LM80C_BOOT_INDEX) || (idx == `LM80C_ROM_INDEX);
		ioctl_download = 1'b1;
		ioctl_index    = idx;
		next_cycle();
		foreach (target_addrs[i]) begin
			rnd        = $random(seed);
			ioctl_addr = dl_addr_t'(target_addrs[i]);
			ioctl_dout = rnd[7:0];
			ioctl_wr   = 1'b1;
			next_cycle();
			ioctl_wr = 1'b0;
			if (accepted)
				model_mem[`LM80C_ROM_BASE + target_addrs[i]] = rnd[7:0];
			check_value("cpu_reset", 1, cpu_reset);
			check_value("cpu_wait", 1, cpu_wait);
			next_cycle();
		end
		ioctl_download = 1'b0;
		// Loaded flag rises on the edge that ends the download
		next_cycle();
		if (accepted)
			model_rom_loaded = 1'b1;
		check_value("cpu_wait", !model_rom_loaded, cpu_wait);
		check_value("cpu_reset", !model_rom_loaded, cpu_reset);
	endtask

	// ========================================
	// Test sequence
	// ========================================

	initial begin : main_seq
		int          i;
		int          cycles;
		int          vdp_count;
		int          z80_count;
		int          psg_count;
		int          assert_fails;
		logic [31:0] rnd;
		cpu_addr_t   addr;
		mem_data_t   hold_val;

		seed        = 32'hd86cc834;
		error_count = 0;
		check_count = 0;

		rst            = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		user_reset     = 1'b0;
		menu_reset     = 1'b0;
		cpu_addr       = '0;
		cpu_dout       = '0;
		cpu_rd         = 1'b0;
		cpu_wr         = 1'b0;
		rom_enable     = 1'b1;
		model_rom_loaded = 1'b0;

		// Enable rates over 64 cycles from reset release
		apply_reset();
		vdp_count = 0;
		z80_count = 0;
		psg_count = 0;
		for (i = 0; i < 64; i++) begin
			next_cycle();
			vdp_count += vdp_ena;
			z80_count += z80_ena;
			psg_count += psg_ena;
		end
		check_value("vdp_ena count", 16, vdp_count);
		check_value("z80_ena count", 8, z80_count);
		check_value("psg_ena count", 4, psg_count);

		// Rejected index over CPU-written ROM bytes
		apply_reset();
		target_addrs.delete();
		for (i = 0; i < 8; i++) begin
			rnd = $random(seed);
			target_addrs.push_back(rnd[14:0]);
			cpu_write({1'b0, rnd[14:0]}, 1'b1, rnd[23:16]);
		end
		run_download(8'd5);
		foreach (target_addrs[j])
			cpu_read({1'b0, target_addrs[j]}, 1'b1);

		// Boot image, random bytes below 8000 hex
		target_addrs.delete();
		for (i = 0; i < 24; i++) begin
			rnd = $random(seed);
			target_addrs.push_back(rnd[14:0]);
		end
		run_download(`LM80C_ROM_INDEX);
		foreach (target_addrs[j])
			cpu_read({1'b0, target_addrs[j]}, 1'b1);

		// Write into ROM-mapped space and read it from both banks
		rnd  = $random(seed);
		addr = {1'b0, rnd[14:0]};
		cpu_write(addr, 1'b1, rnd[23:16]);
		cpu_read(addr, 1'b1);
		cpu_read(addr, 1'b0);

		// Random CPU traffic, reads mostly hit earlier writes
		for (i = 0; i < 200; i++) begin
			rnd = $random(seed);
			if (rnd[0] || (cpu_written.size() == 0)) begin
				addr = rnd[31:16];
				cpu_write(addr, rnd[1], rnd[15:8]);
				cpu_written.push_back(addr);
			end else begin
				addr = cpu_written[rnd[31:8] % cpu_written.size()];
				cpu_read(addr, rnd[1]);
			end
		end

		// Nonzero bytes over the erase window and one above it
		for (i = 0; i <= ERASE_WORDS; i++) begin
			rnd = $random(seed);
			cpu_write(cpu_addr_t'(i), 1'b0, rnd[7:0] | 8'h01);
		end
		menu_reset = 1'b1;
		next_cycle();
		menu_reset = 1'b0;
		check_value("erasing", 1, erasing);
		check_value("cpu_reset", 1, cpu_reset);
		cycles = 0;
		while ((erasing === 1'b1) && (cycles < WAIT_LIMIT)) begin
			check_value("cpu_reset", 1, cpu_reset);
			next_cycle();
			cycles++;
		end
		if (erasing !== 1'b0) begin
			error_count++;
			$display("Timeout: erasing still high after %0d cycles", WAIT_LIMIT);
		end
		for (i = 0; i < ERASE_WORDS; i++)
			model_mem[`LM80C_RAM_BASE + i] = `LM80C_ERASE_FILL;
		for (i = 0; i <= ERASE_WORDS; i++)
			cpu_read(cpu_addr_t'(i), 1'b0);

		// mem_q holds while rd is low and the address moves
		rnd  = $random(seed);
		addr = rnd[15:0];
		cpu_write(addr, 1'b0, rnd[23:16]);
		cpu_read(addr, 1'b0);
		hold_val = model_mem[map_cpu_addr(addr, 1'b0)];
		for (i = 0; i < 8; i++) begin
			rnd        = $random(seed);
			cpu_addr   = rnd[15:0];
			rom_enable = rnd[16];
			next_cycle();
			check_value("mem_q hold", hold_val, mem_q);
		end

		assert_fails = DUT.u_lm80c_mem_assert.assert_fails;
		$display("Checks %0d, check errors %0d, assertion failures %0d",
			check_count, error_count, assert_fails);
		if ((error_count == 0) && (assert_fails == 0))
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/lm80c_mem_assert.sv ====
/*
  LM80C memory subsystem assertions
  Enable nesting and CPU hold rules, bound to the top level
*/
`default_nettype none

module lm80c_mem_assert (
	input logic clk_sys,
	input logic rst,
	input logic downloading,
	input logic psg_ena,
	input logic z80_ena,
	input logic cpu_wait,
	input logic cpu_reset,
	input logic erasing
);

	// Failure tally, read by the testbench at the end
	int assert_fails = 0;

	// Sound enable always lands on a CPU enable
	psg_in_z80: assert property (@(posedge clk_sys) disable iff (rst)
		psg_ena |-> z80_ena)
	else begin
		assert_fails++;
		$error("psg_ena high without z80_ena");
	end

	// CPU waits for the whole download
	wait_in_download: assert property (@(posedge clk_sys) disable iff (rst)
		downloading |-> cpu_wait)
	else begin
		assert_fails++;
		$error("cpu_wait low during a download");
	end

	// CPU held in reset over an erase run
	reset_in_erase: assert property (@(posedge clk_sys) disable iff (rst)
		erasing |-> cpu_reset)
	else begin
		assert_fails++;
		$error("cpu_reset low while erasing");
	end

endmodule

bind lm80c_mem lm80c_mem_assert u_lm80c_mem_assert (
	.clk_sys     (clk_sys),
	.rst         (rst),
	.downloading (downloading),
	.psg_ena     (psg_ena),
	.z80_ena     (z80_ena),
	.cpu_wait    (cpu_wait),
	.cpu_reset   (cpu_reset),
	.erasing     (erasing)
);

`default_nettype wire

// ==== design/lm80c_mem.sv ====
/*
  LM80C memory and boot subsystem
  Clock enables, ROM loader, RAM eraser, port arbiter
  and system memory behind plain ports
*/
`default_nettype none

`include "lm80c_mem_settings.svh"

module lm80c_mem #(
	parameter int ERASE_WORDS = 65536
) (
	input  logic                      clk_sys,
	input  logic                      rst,
	input  logic                      ioctl_download,
	input  lm80c_mem_pkg::dl_index_t  ioctl_index,
	input  lm80c_mem_pkg::dl_addr_t   ioctl_addr,
	input  lm80c_mem_pkg::mem_data_t  ioctl_dout,
	input  logic                      ioctl_wr,
	input  logic                      user_reset,
	input  logic                      menu_reset,
	input  lm80c_mem_pkg::cpu_addr_t  cpu_addr,
	input  lm80c_mem_pkg::mem_data_t  cpu_dout,
	input  logic                      cpu_rd,
	input  logic                      cpu_wr,
	input  logic                      rom_enable,
	output lm80c_mem_pkg::mem_data_t  mem_q,
	output logic                      vdp_ena,
	output logic                      z80_ena,
	output logic                      psg_ena,
	output logic                      cpu_reset,
	output logic                      cpu_wait,
	output logic                      erasing
);

	// Loader status
	logic downloading;

	// Requests towards the arbiter, and its output
	mem_req_if loader_req ();
	mem_req_if eraser_req ();
	mem_req_if mem_port ();

	// ========================================
	// Timing and control
	// ========================================

	clock_enables u_clock_enables (
		.clk_sys (clk_sys),
		.rst     (rst),
		.vdp_ena (vdp_ena),
		.z80_ena (z80_ena),
		.psg_ena (psg_ena)
	);

	rom_loader u_rom_loader (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr),
		.user_reset     (user_reset),
		.erasing        (erasing),
		.downloading    (downloading),
		.rom_loaded     (),
		.cpu_reset      (cpu_reset),
		.cpu_wait       (cpu_wait),
		.req            (loader_req)
	);

	// Eraser steps at the CPU enable rate
	ram_eraser #(
		.ERASE_WORDS (ERASE_WORDS)
	) u_ram_eraser (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.z80_ena    (z80_ena),
		.menu_reset (menu_reset),
		.erasing    (erasing),
		.req        (eraser_req)
	);

	// ========================================
	// Memory path
	// ========================================

	mem_arbiter u_mem_arbiter (
		.downloading (downloading),
		.erasing     (erasing),
		.loader_req  (loader_req),
		.eraser_req  (eraser_req),
		.cpu_addr    (cpu_addr),
		.cpu_dout    (cpu_dout),
		.cpu_rd      (cpu_rd),
		.cpu_wr      (cpu_wr),
		.rom_enable  (rom_enable),
		.mem_port    (mem_port)
	);

	system_memory #(
		.ADDR_W (`LM80C_MEM_ADDR_W)
	) u_system_memory (
		.clk_sys (clk_sys),
		.port    (mem_port),
		.q       (mem_q)
	);

endmodule

`default_nettype wire

// ==== design/system_memory.sv ====
/*
  System memory
  Single-port byte array holding ROM and RAM banks,
  synchronous write and read-enabled registered output
*/
`default_nettype none

module system_memory #(
	parameter int ADDR_W = 17
) (
	input  logic                      clk_sys,
	mem_req_if.memory                 port,
	output lm80c_mem_pkg::mem_data_t  q
);

	localparam int DEPTH = 2 ** ADDR_W;

	// Byte storage
	lm80c_mem_pkg::mem_data_t mem [DEPTH];

	logic [ADDR_W-1:0] addr;

	// Upper address bits beyond the array are dropped
	assign addr = port.addr[ADDR_W-1:0];

	// ========================================
	// Access
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (port.wr)
			mem[addr] <= port.data;
	end

	// Read returns the old byte on a write cycle,
	// and q holds while rd is low
	always_ff @(posedge clk_sys) begin
		if (port.rd)
			q <= mem[addr];
	end

endmodule

`default_nettype wire

// ==== design/mem_arbiter.sv ====
/*
  Memory port arbiter
  Fixed priority of loader, eraser, then CPU onto the single
  memory port, with CPU addresses mapped onto the ROM and RAM banks
*/
`default_nettype none

module mem_arbiter (
	input  logic                      downloading,
	input  logic                      erasing,
	mem_req_if.memory                 loader_req,
	mem_req_if.memory                 eraser_req,
	input  lm80c_mem_pkg::cpu_addr_t  cpu_addr,
	input  lm80c_mem_pkg::mem_data_t  cpu_dout,
	input  logic                      cpu_rd,
	input  logic                      cpu_wr,
	input  logic                      rom_enable,
	mem_req_if.requester              mem_port
);

	import lm80c_mem_pkg::*;

	// CPU side after bank mapping
	logic      ram_bank;
	mem_addr_t cpu_phys;

	// ========================================
	// Bank mapping
	// ========================================

	// Memory map
	//   0-0000 .. 0-7FFF  32K ROM
	//   0-8000 .. 0-FFFF  unused
	//   1-0000 .. 1-FFFF  64K RAM
	// ROM shows only in the lower half with rom_enable set
	assign ram_bank = !rom_enable || cpu_addr[15];
	assign cpu_phys = {ram_bank, cpu_addr};

	// ========================================
	// Priority select
	// ========================================

	always_comb begin
		if (downloading && loader_req.wr) begin
			// Loader write strobe
			mem_port.addr = loader_req.addr;
			mem_port.data = loader_req.data;
			mem_port.wr   = loader_req.wr;
			mem_port.rd   = loader_req.rd;
		end else if (erasing) begin
			// Eraser owns the port for the whole run
			mem_port.addr = eraser_req.addr;
			mem_port.data = eraser_req.data;
			mem_port.wr   = eraser_req.wr;
			mem_port.rd   = eraser_req.rd;
		end else begin
			// CPU strobes go through unchanged
			mem_port.addr = cpu_phys;
			mem_port.data = cpu_dout;
			mem_port.wr   = cpu_wr;
			mem_port.rd   = cpu_rd;
		end
	end

	// No back-pressure, CPU is held in reset or wait
	// whenever a higher priority requester is active

endmodule

`default_nettype wire

// ==== design/ram_eraser.sv ====
/*
  RAM eraser
  After a menu reset pulse, writes the fill byte over
  ERASE_WORDS bytes of the RAM bank, one byte per CPU enable
*/
`default_nettype none

`include "lm80c_mem_settings.svh"

module ram_eraser #(
	parameter int ERASE_WORDS = 65536
) (
	input  logic         clk_sys,
	input  logic         rst,
	input  logic         z80_ena,
	input  logic         menu_reset,
	output logic         erasing,
	mem_req_if.requester req
);

	import lm80c_mem_pkg::*;

	localparam int CNT_W = (ERASE_WORDS > 1) ? $clog2(ERASE_WORDS) : 1;
	localparam logic [CNT_W-1:0] LAST = CNT_W'(ERASE_WORDS - 1);

	// Offset into the RAM bank
	logic [CNT_W-1:0] cnt;
	logic             step;

	// One byte per CPU enable while busy
	assign step = erasing && z80_ena;

	// ========================================
	// Sequencer
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			erasing <= 1'b0;
			cnt     <= '0;
		end else if (!erasing) begin
			// Start from the RAM base on a trigger
			if (menu_reset) begin
				erasing <= 1'b1;
				cnt     <= '0;
			end
		end else if (step) begin
			// Last byte clears busy on this edge
			if (cnt == LAST)
				erasing <= 1'b0;
			cnt <= cnt + 1'b1;
		end
	end

	// Triggers during a run fall through the idle branch

	// ========================================
	// Request
	// ========================================

	assign req.addr = `LM80C_RAM_BASE + mem_addr_t'(cnt);
	assign req.data = `LM80C_ERASE_FILL;
	assign req.wr   = step;
	// Read goes along with each write
	assign req.rd   = step;

endmodule

`default_nettype wire

// ==== design/rom_loader.sv ====
/*
  ROM image loader
  Writes download bytes with a ROM index into the ROM bank,
  tracks the end of a boot download and derives the CPU
  reset and wait levels
*/
`default_nettype none

`include "lm80c_mem_settings.svh"

module rom_loader (
	input  logic                      clk_sys,
	input  logic                      rst,
	input  logic                      ioctl_download,
	input  lm80c_mem_pkg::dl_index_t  ioctl_index,
	input  lm80c_mem_pkg::dl_addr_t   ioctl_addr,
	input  lm80c_mem_pkg::mem_data_t  ioctl_dout,
	input  logic                      ioctl_wr,
	input  logic                      user_reset,
	input  logic                      erasing,
	output logic                      downloading,
	output logic                      rom_loaded,
	output logic                      cpu_reset,
	output logic                      cpu_wait,
	mem_req_if.requester              req
);

	import lm80c_mem_pkg::*;

	// Index of the download in progress
	dl_index_t dl_index;
	logic      wr_accept;

	// True for the indexes that carry a ROM image
	function automatic logic is_rom_index(input dl_index_t idx);
		return (idx == `LM80C_BOOT_INDEX) || (idx == `LM80C_ROM_INDEX);
	endfunction

	// ========================================
	// Download tracking
	// ========================================

	// Index only matters while a download runs
	always_ff @(posedge clk_sys) begin
		if (ioctl_download)
			dl_index <= ioctl_index;
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			downloading <= 1'b0;
			rom_loaded  <= 1'b0;
		end else begin
			downloading <= ioctl_download;
			// Falling edge of an accepted download
			if (downloading && !ioctl_download && is_rom_index(dl_index))
				rom_loaded <= 1'b1;
		end
	end

	// ========================================
	// Memory writes
	// ========================================

	// Other indexes pass by without a write
	assign wr_accept = ioctl_download && ioctl_wr && is_rom_index(ioctl_index);

	assign req.addr = `LM80C_ROM_BASE + ioctl_addr[`LM80C_MEM_ADDR_W-1:0];
	assign req.data = ioctl_dout;
	assign req.wr   = wr_accept;
	assign req.rd   = wr_accept;

	// CPU held until a ROM is in place
	assign cpu_wait  = !rom_loaded || downloading;
	assign cpu_reset = rst || user_reset || erasing || !rom_loaded;

endmodule

`default_nettype wire

// ==== design/clock_enables.sv ====
/*
  Clock enable generator
  Divides clk_sys into the video (1/4), CPU (1/8)
  and sound (1/16) enable pulses
*/
`default_nettype none

`include "lm80c_mem_settings.svh"

module clock_enables (
	input  logic clk_sys,
	input  logic rst,
	output logic vdp_ena,
	output logic z80_ena,
	output logic psg_ena
);

	import lm80c_mem_pkg::*;

	vdp_div_t vdp_cnt;
	cpu_div_t cpu_cnt;

	// ========================================
	// Dividers
	// ========================================

	// Both counters start at zero, so the first
	// enable of every kind comes together
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			vdp_cnt <= '0;
			cpu_cnt <= '0;
			vdp_ena <= 1'b0;
			z80_ena <= 1'b0;
			psg_ena <= 1'b0;
		end else begin
			vdp_cnt <= vdp_cnt + 1'b1;
			cpu_cnt <= cpu_cnt + 1'b1;
			// Video pixel enable on counter wrap
			vdp_ena <= (vdp_cnt == '0);
			// CPU runs at twice the sound rate
			z80_ena <= (cpu_cnt == `LM80C_Z80_PHASE_A) ||
				(cpu_cnt == `LM80C_Z80_PHASE_B);
			// PSG only on the first CPU phase
			psg_ena <= (cpu_cnt == `LM80C_PSG_PHASE);
		end
	end

endmodule

`default_nettype wire

// ==== design/mem_req_if.sv ====
/*
  Memory request bundle
  One requester drives address, data, write and read strobes
  towards the memory side
*/
`default_nettype none

interface mem_req_if;

	// Physical byte address
	lm80c_mem_pkg::mem_addr_t addr;

	// Write data
	lm80c_mem_pkg::mem_data_t data;

	// Write strobe, one byte per cycle
	logic wr;

	// Read enable for the registered output
	logic rd;

	// Loader, eraser and arbiter output side
	modport requester (
		output addr,
		output data,
		output wr,
		output rd
	);

	// Arbiter input side and the memory
	modport memory (
		input addr,
		input data,
		input wr,
		input rd
	);

endinterface

`default_nettype wire

// ==== design/lm80c_mem_pkg.sv ====
/*
  LM80C memory subsystem package
  Address, data, download and divider types shared by the blocks
*/
`default_nettype none

`include "lm80c_mem_settings.svh"

package lm80c_mem_pkg;

	// ========================================
	// Memory side
	// ========================================

	// Physical address, bank bit on top of a 16-bit offset
	typedef logic [`LM80C_MEM_ADDR_W-1:0] mem_addr_t;

	// Address as seen by the Z80
	typedef logic [15:0] cpu_addr_t;

	// One byte of memory
	typedef logic [7:0] mem_data_t;

	// ========================================
	// Download side
	// ========================================

	typedef logic [7:0] dl_index_t;
	typedef logic [24:0] dl_addr_t;

	// Free-running divider counters
	typedef logic [`LM80C_VDP_DIV_W-1:0] vdp_div_t;
	typedef logic [`LM80C_CPU_DIV_W-1:0] cpu_div_t;

endpackage

`default_nettype wire

// ==== design/lm80c_mem_settings.svh ====
/*
  LM80C memory subsystem settings
  Widths, bank bases, download indexes, fill byte
  and clock divider decode patterns
*/
`ifndef LM80C_MEM_SETTINGS_SVH
`define LM80C_MEM_SETTINGS_SVH

// Physical memory, 128K bytes with two 64K banks
`define LM80C_MEM_ADDR_W 17
`define LM80C_ROM_BASE 17'h00000
`define LM80C_RAM_BASE 17'h10000

// Download indexes that carry a ROM image
`define LM80C_BOOT_INDEX 8'd0
`define LM80C_ROM_INDEX 8'd3

// Byte written over RAM by the eraser
`define LM80C_ERASE_FILL 8'h00

// Divider counters and their decode phases
`define LM80C_VDP_DIV_W 2
`define LM80C_CPU_DIV_W 4
`define LM80C_Z80_PHASE_A 4'd0
`define LM80C_Z80_PHASE_B 4'd8
`define LM80C_PSG_PHASE 4'd0

`endif
